// ==== tb.f ====
+incdir+tb
source/des_pkg.sv
source/wb_regs_pkg.sv
source/des_sbox.sv
source/des_engine.sv
source/des3_sequencer.sv
source/des3_top.sv
tb/tb_des3_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the 3DES testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_des3_top \
   -f tb.f --Mdir "$build_dir" -o tb_des3_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/tb_des3_top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TESTS PASSED$" "$log"; then
   exit 0
fi
echo "Pass line not found in $log"
exit 1

// ==== tb/tb_des3_tasks.svh ====
//////////////////////////////
// Wishbone access

task automatic bus_cycle(input logic we, input logic [3:0] idx, input wb_data_t wdata,
                         output wb_data_t rdata);
   int waited;

   waited = 0;
   @(posedge wb_clk);
   assert (wb_ack === 1'b0) else begin
      $display("Wishbone acknowledge is high while no cycle is open.");
      end_failed_run();
   end
   wb_adr   <= wb_addr_t'({idx, 2'b00});
   wb_dat_w <= wdata;
   wb_sel   <= 4'hf;
   wb_we    <= we;
   wb_cyc   <= 1'b1;
   wb_stb   <= 1'b1;
   @(posedge wb_clk);
   while (!wb_ack) begin
      waited++;
      if (waited > ACK_TIMEOUT) begin
         $display("No Wishbone acknowledge for word %0d.", idx);
         end_failed_run();
      end
      @(posedge wb_clk);
   end
   check_value("wb_ack_wait_states", 64'd0, 64'(waited));
   rdata = wb_dat_r;  // Sampled before this edge's register updates land.
   wb_cyc <= 1'b0;
   wb_stb <= 1'b0;
   wb_we  <= 1'b0;
endtask

task automatic wb_write(input logic [3:0] idx, input wb_data_t data);
   wb_data_t unused;
   bus_cycle(1'b1, idx, data, unused);
endtask

task automatic wb_read(input logic [3:0] idx, output wb_data_t data);
   bus_cycle(1'b0, idx, '0, data);
endtask

task automatic check_value(input string test, input logic [63:0] expected,
                           input logic [63:0] actual);
   assert (actual === expected) else begin
      $display("** Error [%s] expected %h, actual %h", test, expected, actual);
      end_failed_run();
   end
endtask

//////////////////////////////
// Coprocessor access

task automatic wait_valid(input string test, input logic level);
   wb_data_t rd;
   int       waited;

   waited = 0;
   wb_read(REG_VALID, rd);
   while (rd[0] !== level) begin
      waited += 2;  // One read spans two clocks.
      if (waited > POLL_TIMEOUT) begin
         $display("Valid bit never reached %0d in test %s.", level, test);
         end_failed_run();
      end
      wb_read(REG_VALID, rd);
   end
endtask

task automatic load_operands(input des_key_t k1, input des_key_t k2, input des_key_t k3,
                             input des_block_t blk, input logic dec);
   wb_write(REG_KEY1_HI, k1[63:32]);
   wb_write(REG_KEY1_LO, k1[31:0]);
   wb_write(REG_KEY2_HI, k2[63:32]);
   wb_write(REG_KEY2_LO, k2[31:0]);
   wb_write(REG_KEY3_HI, k3[63:32]);
   wb_write(REG_KEY3_LO, k3[31:0]);
   wb_write(REG_DIN_HI, blk[63:32]);
   wb_write(REG_DIN_LO, blk[31:0]);
   wb_write(REG_DECRYPT, wb_data_t'(dec));
endtask

task automatic read_result(output des_block_t res);
   wb_data_t hi;
   wb_data_t lo;

   wb_read(REG_DOUT_HI, hi);
   wb_read(REG_DOUT_LO, lo);
   res = {hi, lo};
endtask

// One full request. Start, poll, fetch and release the handshake.
task automatic run_des3(input string test, input des_key_t k1, input des_key_t k2,
                        input des_key_t k3, input des_block_t blk, input logic dec,
                        output des_block_t res);
   load_operands(k1, k2, k3, blk, dec);
   wb_write(REG_START, 32'd1);
   wait_valid(test, 1'b1);
   read_result(res);
   wb_write(REG_START, 32'd0);
   wait_valid(test, 1'b0);
endtask

//////////////////////////////
// Directed tests

task automatic test_reset_readback();
   wb_data_t rd;
   wb_data_t val;

   for (int i = 0; i < 16; i++) begin
      wb_read(4'(i), rd);
      check_value("reset_readback", 64'd0, 64'(rd));
   end
   wb_write(REG_DECRYPT, 32'hffff_ffff);
   wb_read(REG_DECRYPT, rd);
   check_value("decrypt_bit", 64'd1, 64'(rd));  // Only bit 0 is stored.
   for (int i = REG_DIN_HI; i <= REG_KEY1_LO; i++) begin
      val = $random(seed);
      wb_write(4'(i), val);
      wb_read(4'(i), rd);
      check_value("word_readback", 64'(val), 64'(rd));
   end
   wb_write(REG_DOUT_LO, 32'hdead_beef);
   wb_read(REG_DOUT_LO, rd);
   check_value("dout_write_ignored", 64'd0, 64'(rd));
   wb_read(4'd15, rd);
   check_value("unmapped_word", 64'd0, 64'(rd));
endtask

task automatic test_known_encrypt();
   des_block_t res;
   run_des3("known_encrypt", KNOWN_KEY, KNOWN_KEY, KNOWN_KEY, KNOWN_PT, 1'b0, res);
   check_value("known_encrypt", KNOWN_CT, res);
endtask

task automatic test_known_decrypt();
   des_block_t res;
   run_des3("known_decrypt", KNOWN_KEY, KNOWN_KEY, KNOWN_KEY, KNOWN_CT, 1'b1, res);
   check_value("known_decrypt", KNOWN_PT, res);
endtask

task automatic test_round_trip();
   des_key_t   k1, k2, k3;
   des_block_t pt, ct, back;

   for (int n = 0; n < RT_ROUNDS; n++) begin
      k1 = {$random(seed), $random(seed)};
      k2 = {$random(seed), $random(seed)};
      k3 = {$random(seed), $random(seed)};
      pt = {$random(seed), $random(seed)};
      run_des3("round_trip_enc", k1, k2, k3, pt, 1'b0, ct);
      run_des3("round_trip_dec", k1, k2, k3, ct, 1'b1, back);
      check_value("round_trip", pt, back);
   end
endtask

task automatic test_handshake();
   wb_data_t   rd;
   des_block_t first, again;

   load_operands(KNOWN_KEY, KNOWN_KEY, KNOWN_KEY, KNOWN_PT, 1'b0);
   wb_read(REG_VALID, rd);
   check_value("valid_before_start", 64'd0, 64'(rd));
   wb_write(REG_START, 32'd1);
   wait_valid("handshake", 1'b1);
   read_result(first);
   check_value("handshake_result", KNOWN_CT, first);

   // New operands must not disturb a result that is already held.
   wb_write(REG_DIN_HI, 32'hffff_ffff);
   wb_write(REG_DIN_LO, 32'h5555_aaaa);
   for (int i = 0; i < 4; i++) begin
      wb_read(REG_VALID, rd);
      check_value("valid_held", 64'd1, 64'(rd));
      read_result(again);
      check_value("result_held", KNOWN_CT, again);
   end

   wb_write(REG_START, 32'd0);
   wait_valid("handshake_release", 1'b0);
endtask

// ==== tb/tb_des3_top.sv ====
`timescale 1ns/1ps

module tb_des3_top;

   import wb_regs_pkg::*;
   import des_pkg::*;

   localparam int ACK_TIMEOUT  = 8;    // Cycles before a missing acknowledge is reported.
   localparam int POLL_TIMEOUT = 200;  // Cycles spent polling the valid word.
   localparam int RT_ROUNDS    = 4;

   // Classic single-DES vector. EDE with three equal keys reduces to it.
   localparam des_key_t   KNOWN_KEY = 64'h1334_5779_9bbc_dff1;
   localparam des_block_t KNOWN_PT  = 64'h0123_4567_89ab_cdef;
   localparam des_block_t KNOWN_CT  = 64'h85e8_1354_0f0a_b405;

   logic       wb_clk = 1'b0;
   logic       wb_rst;
   wb_addr_t   wb_adr;
   logic       wb_cyc;
   wb_data_t   wb_dat_w;
   logic [3:0] wb_sel;
   logic       wb_stb;
   logic       wb_we;
   logic       wb_ack;
   wb_data_t   wb_dat_r;

   integer     seed = 32'h18c4196d;

   always #5 wb_clk = ~wb_clk;

   des3_top DUT (
      .wb_clk_i (wb_clk),
      .wb_rst_i (wb_rst),
      .wb_adr_i (wb_adr),
      .wb_cyc_i (wb_cyc),
      .wb_dat_i (wb_dat_w),
      .wb_sel_i (wb_sel),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_ack_o (wb_ack),
      .wb_dat_o (wb_dat_r)
   );

   task automatic end_failed_run();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped after the first failure");
   endtask

   `include "tb_des3_tasks.svh"

   //////////////////////////////
   // Test sequence
   initial begin
      wb_rst   = 1'b1;
      wb_adr   = '0;
      wb_cyc   = 1'b0;
      wb_dat_w = '0;
      wb_sel   = 4'h0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;

      repeat (2) @(posedge wb_clk);
      wb_rst <= 1'b0;

      test_reset_readback();
      test_known_encrypt();
      test_known_decrypt();
      test_round_trip();
      test_handshake();

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// ==== source/des3_top.sv ====
`timescale 1ns/1ps

module des3_top (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  wb_regs_pkg::wb_addr_t wb_adr_i,
   input  logic                  wb_cyc_i,
   input  wb_regs_pkg::wb_data_t wb_dat_i,
   input  logic [3:0]            wb_sel_i,  // Every register is a full word.
   input  logic                  wb_stb_i,
   input  logic                  wb_we_i,
   output logic                  wb_ack_o,
   output wb_regs_pkg::wb_data_t wb_dat_o
);

   import wb_regs_pkg::*;
   import des_pkg::*;

   logic       start_q, decrypt_q;
   wb_data_t   din_hi_q, din_lo_q;
   wb_data_t   key1_hi_q, key1_lo_q;
   wb_data_t   key2_hi_q, key2_lo_q;
   wb_data_t   key3_hi_q, key3_lo_q;

   logic [3:0] reg_idx;
   logic       wr_en;
   logic       valid;
   des_block_t din, dout;
   des_key_t   key1, key2, key3;

   assign reg_idx  = wb_adr_i[REG_IDX_MSB:REG_IDX_LSB];
   assign wr_en    = wb_cyc_i & wb_stb_i & wb_we_i;
   assign wb_ack_o = wb_cyc_i & wb_stb_i;  // No wait states.

   assign din  = {din_hi_q, din_lo_q};
   assign key1 = {key1_hi_q, key1_lo_q};
   assign key2 = {key2_hi_q, key2_lo_q};
   assign key3 = {key3_hi_q, key3_lo_q};

   //////////////////////////////
   // Write side
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         start_q   <= 1'b0;
         decrypt_q <= 1'b0;
         din_hi_q  <= '0;
         din_lo_q  <= '0;
         key1_hi_q <= '0;
         key1_lo_q <= '0;
         key2_hi_q <= '0;
         key2_lo_q <= '0;
         key3_hi_q <= '0;
         key3_lo_q <= '0;
      end else if (wr_en) begin
         case (reg_idx)
            REG_START:   start_q   <= wb_dat_i[0];  // Doubles as the request.
            REG_DECRYPT: decrypt_q <= wb_dat_i[0];
            REG_DIN_HI:  din_hi_q  <= wb_dat_i;
            REG_DIN_LO:  din_lo_q  <= wb_dat_i;
            REG_KEY3_HI: key3_hi_q <= wb_dat_i;
            REG_KEY3_LO: key3_lo_q <= wb_dat_i;
            REG_KEY2_HI: key2_hi_q <= wb_dat_i;
            REG_KEY2_LO: key2_lo_q <= wb_dat_i;
            REG_KEY1_HI: key1_hi_q <= wb_dat_i;
            REG_KEY1_LO: key1_lo_q <= wb_dat_i;
            default: ;
         endcase
      end
   end

   //////////////////////////////
   // Read side
   always_comb begin
      case (reg_idx)
         REG_START:   wb_dat_o = wb_data_t'(start_q);
         REG_DECRYPT: wb_dat_o = wb_data_t'(decrypt_q);
         REG_DIN_HI:  wb_dat_o = din_hi_q;
         REG_DIN_LO:  wb_dat_o = din_lo_q;
         REG_KEY3_HI: wb_dat_o = key3_hi_q;
         REG_KEY3_LO: wb_dat_o = key3_lo_q;
         REG_KEY2_HI: wb_dat_o = key2_hi_q;
         REG_KEY2_LO: wb_dat_o = key2_lo_q;
         REG_KEY1_HI: wb_dat_o = key1_hi_q;
         REG_KEY1_LO: wb_dat_o = key1_lo_q;
         REG_VALID:   wb_dat_o = wb_data_t'(valid);
         REG_DOUT_HI: wb_dat_o = dout[63:32];
         REG_DOUT_LO: wb_dat_o = dout[31:0];
         default:     wb_dat_o = '0;
      endcase
   end

   des3_sequencer u_seq (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .req_i     (start_q),
      .decrypt_i (decrypt_q),
      .din_i     (din),
      .key1_i    (key1),
      .key2_i    (key2),
      .key3_i    (key3),
      .ack_o     (valid),
      .dout_o    (dout)
   );

endmodule

// ==== source/des3_sequencer.sv ====
`timescale 1ns/1ps

module des3_sequencer (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                req_i,
   input  logic                decrypt_i,
   input  des_pkg::des_block_t din_i,
   input  des_pkg::des_key_t   key1_i,
   input  des_pkg::des_key_t   key2_i,
   input  des_pkg::des_key_t   key3_i,
   output logic                ack_o,
   output des_pkg::des_block_t dout_o
);

   import des_pkg::*;

   typedef enum logic [2:0] {
      SEQ_IDLE,
      SEQ_PASS1,
      SEQ_PASS2,
      SEQ_PASS3,
      SEQ_HOLD
   } seq_state_e;

   seq_state_e state_q;
   logic       ack_q;
   logic       load_q;
   logic       dec_q;
   des_block_t din_q, dout_q;
   des_key_t   key1_q, key2_q, key3_q;

   logic       eng_load, eng_dec, eng_done;
   des_block_t eng_block, eng_out;
   des_key_t   eng_key;

   // Pass one launches from load_q. Later passes start straight off done.
   always_comb begin
      eng_load  = load_q;
      eng_block = din_q;
      eng_key   = dec_q ? key3_q : key1_q;
      eng_dec   = dec_q;
      if (eng_done && state_q == SEQ_PASS1) begin
         eng_load  = 1'b1;
         eng_block = eng_out;
         eng_key   = key2_q;
         eng_dec   = !dec_q;  // Middle pass runs the other direction.
      end else if (eng_done && state_q == SEQ_PASS2) begin
         eng_load  = 1'b1;
         eng_block = eng_out;
         eng_key   = dec_q ? key1_q : key3_q;
      end
   end

   des_engine u_engine (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .load_i    (eng_load),
      .decrypt_i (eng_dec),
      .block_i   (eng_block),
      .key_i     (eng_key),
      .done_o    (eng_done),
      .block_o   (eng_out)
   );

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q <= SEQ_IDLE;
         ack_q   <= 1'b0;
         load_q  <= 1'b0;
         dout_q  <= '0;
      end else begin
         load_q <= 1'b0;
         case (state_q)
            SEQ_IDLE: if (req_i) begin
               state_q <= SEQ_PASS1;
               load_q  <= 1'b1;
            end
            SEQ_PASS1: if (eng_done) state_q <= SEQ_PASS2;
            SEQ_PASS2: if (eng_done) state_q <= SEQ_PASS3;
            SEQ_PASS3: if (eng_done) begin
               state_q <= SEQ_HOLD;
               ack_q   <= 1'b1;
               dout_q  <= eng_out;
            end
            SEQ_HOLD: if (!req_i) begin
               state_q <= SEQ_IDLE;
               ack_q   <= 1'b0;
            end
            default: state_q <= SEQ_IDLE;
         endcase
      end
   end

   // Operands are frozen for the whole computation.
   always_ff @(posedge wb_clk_i) begin
      if (state_q == SEQ_IDLE && req_i) begin
         dec_q  <= decrypt_i;
         din_q  <= din_i;
         key1_q <= key1_i;
         key2_q <= key2_i;
         key3_q <= key3_i;
      end
   end

   assign ack_o  = ack_q;
   assign dout_o = dout_q;

   a_ack_with_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $rose(ack_q) |-> req_i);

   a_no_done_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      state_q == SEQ_IDLE |-> !eng_done);

endmodule

// ==== source/des_engine.sv ====
`timescale 1ns/1ps

module des_engine (
   input  logic                wb_clk_i,
   input  logic                wb_rst_i,
   input  logic                load_i,
   input  logic                decrypt_i,
   input  des_pkg::des_block_t block_i,
   input  des_pkg::des_key_t   key_i,
   output logic                done_o,
   output des_pkg::des_block_t block_o
);

   import des_pkg::*;

   typedef enum logic {
      ENG_IDLE,
      ENG_RUN
   } eng_state_e;

   eng_state_e             state_q;
   logic [DES_ROUND_W-1:0] round_q;
   logic                   done_q;
   logic                   dec_q;
   des_half_t              l_q, r_q;
   des_khalf_t             c_q, d_q;
   des_block_t             block_q;

   des_block_t             ip_blk;
   logic [55:0]            pc1_cd;
   des_half_t              src_l, src_r;
   des_khalf_t             src_c, src_d;
   logic [DES_ROUND_W-1:0] rnd;
   logic                   dec;
   des_khalf_t             c_nxt, d_nxt;
   des_subkey_t            sbox_x;
   des_half_t              sbox_y;
   des_half_t              l_nxt, r_nxt;
   logic                   last_round;

   assign ip_blk = des_ip(block_i);
   assign pc1_cd = des_pc1(key_i);
   assign last_round = (state_q == ENG_RUN) && (round_q == DES_ROUND_W'(DES_ROUNDS - 1));

   //////////////////////////////
   // Round datapath. The load cycle already computes round one.
   always_comb begin
      if (load_i) begin
         src_l = ip_blk[63:32];
         src_r = ip_blk[31:0];
         src_c = pc1_cd[55:28];
         src_d = pc1_cd[27:0];
         rnd   = '0;
         dec   = decrypt_i;
      end else begin
         src_l = l_q;
         src_r = r_q;
         src_c = c_q;
         src_d = d_q;
         rnd   = round_q;
         dec   = dec_q;
      end

      if (!dec) begin
         c_nxt = des_rotl(src_c, DES_SHIFTS[rnd]);
         d_nxt = des_rotl(src_d, DES_SHIFTS[rnd]);
      end else if (rnd == '0) begin
         c_nxt = src_c;  // K16 equals the unrotated PC1 output.
         d_nxt = src_d;
      end else begin
         c_nxt = des_rotr(src_c, DES_SHIFTS[DES_ROUNDS - rnd]);
         d_nxt = des_rotr(src_d, DES_SHIFTS[DES_ROUNDS - rnd]);
      end

      sbox_x = des_e(src_r) ^ des_pc2({c_nxt, d_nxt});
      l_nxt  = src_r;
      r_nxt  = src_l ^ des_p(sbox_y);
   end

   des_sbox u_sbox (
      .x_i (sbox_x),
      .y_o (sbox_y)
   );

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q <= ENG_IDLE;
         round_q <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= last_round;
         if (load_i) begin
            state_q <= ENG_RUN;
            round_q <= DES_ROUND_W'(1);
         end else if (state_q == ENG_RUN) begin
            round_q <= round_q + 1'b1;
            if (last_round) begin
               state_q <= ENG_IDLE;
            end
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (load_i || state_q == ENG_RUN) begin
         l_q <= l_nxt;
         r_q <= r_nxt;
         c_q <= c_nxt;
         d_q <= d_nxt;
      end
      if (load_i) begin
         dec_q <= decrypt_i;
      end
      if (last_round) begin
         block_q <= des_fp({r_nxt, l_nxt});  // Halves swap after round 16.
      end
   end

   assign done_o  = done_q;
   assign block_o = block_q;

   // The sequencer must wait for done before it loads again.
   a_no_load_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      state_q == ENG_RUN |-> !load_i);

endmodule

// ==== source/des_sbox.sv ====
`timescale 1ns/1ps

module des_sbox (
   input  des_pkg::des_subkey_t x_i,
   output des_pkg::des_half_t   y_o
);

   // One table per box, four rows of sixteen columns each.
   localparam int unsigned SBOX [8][64] = '{
      '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
         0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
         4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
        15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
      '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
         3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
         0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
        13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
      '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
        13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
        13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
         1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
      '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
        13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
        10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
         3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
      '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
        14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
         4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
        11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
      '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
        10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
         9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
         4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
      '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
        13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
         1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
         6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
      '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
         1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
         7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
         2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
   };

   for (genvar g = 0; g < 8; g++) begin : g_box
      logic [5:0] slice;

      assign slice = x_i[47-6*g -: 6];
      // Outer bits pick the row, inner four bits the column.
      assign y_o[31-4*g -: 4] = 4'(SBOX[g][{slice[5], slice[0], slice[4:1]}]);
   end

endmodule

// ==== source/wb_regs_pkg.sv ====
package wb_regs_pkg;

   typedef logic [31:0] wb_addr_t;
   typedef logic [31:0] wb_data_t;

   // Word index lives in address bits 5 to 2.
   localparam int unsigned REG_IDX_MSB = 5;
   localparam int unsigned REG_IDX_LSB = 2;

   localparam logic [3:0] REG_START   = 4'd0;
   localparam logic [3:0] REG_DECRYPT = 4'd1;
   localparam logic [3:0] REG_DIN_HI  = 4'd2;
   localparam logic [3:0] REG_DIN_LO  = 4'd3;
   localparam logic [3:0] REG_KEY3_HI = 4'd4;
   localparam logic [3:0] REG_KEY3_LO = 4'd5;
   localparam logic [3:0] REG_KEY2_HI = 4'd6;
   localparam logic [3:0] REG_KEY2_LO = 4'd7;
   localparam logic [3:0] REG_KEY1_HI = 4'd8;
   localparam logic [3:0] REG_KEY1_LO = 4'd9;
   localparam logic [3:0] REG_VALID   = 4'd10;  // Read only.
   localparam logic [3:0] REG_DOUT_HI = 4'd11;  // Read only.
   localparam logic [3:0] REG_DOUT_LO = 4'd12;  // Read only.

endpackage

// ==== source/des_pkg.sv ====
package des_pkg;

   typedef logic [63:0] des_block_t;
   typedef logic [63:0] des_key_t;    // Parity bits included. PC1 drops them.
   typedef logic [31:0] des_half_t;
   typedef logic [47:0] des_subkey_t;
   typedef logic [27:0] des_khalf_t;  // One of the C and D key halves.

   localparam int unsigned DES_ROUNDS  = 16;
   localparam int unsigned DES_ROUND_W = $clog2(DES_ROUNDS);

   //////////////////////////////
   // Standard tables. Entries are 1-based bit numbers counted from the MSB.
   localparam int unsigned IP_TAB [64] = '{
      58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
      62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
      57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
      61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

   localparam int unsigned FP_TAB [64] = '{
      40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
      38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
      36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
      34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25};

   localparam int unsigned E_TAB [48] = '{
      32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9, 8, 9, 10, 11,
      12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
      22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

   localparam int unsigned P_TAB [32] = '{
      16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
       2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25};

   localparam int unsigned PC1_TAB [56] = '{
      57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
      10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
      63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
      14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4};

   localparam int unsigned PC2_TAB [48] = '{
      14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
      26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
      51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

   localparam int unsigned DES_SHIFTS [DES_ROUNDS] = '{
      1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

   //////////////////////////////
   // Permutation helpers.
   function automatic des_block_t des_ip(des_block_t b);
      des_block_t r;
      for (int i = 0; i < 64; i++) begin
         r[63-i] = b[64-IP_TAB[i]];
      end
      return r;
   endfunction

   function automatic des_block_t des_fp(des_block_t b);
      des_block_t r;
      for (int i = 0; i < 64; i++) begin
         r[63-i] = b[64-FP_TAB[i]];
      end
      return r;
   endfunction

   function automatic des_subkey_t des_e(des_half_t h);
      des_subkey_t r;
      for (int i = 0; i < 48; i++) begin
         r[47-i] = h[32-E_TAB[i]];
      end
      return r;
   endfunction

   function automatic des_half_t des_p(des_half_t h);
      des_half_t r;
      for (int i = 0; i < 32; i++) begin
         r[31-i] = h[32-P_TAB[i]];
      end
      return r;
   endfunction

   function automatic logic [55:0] des_pc1(des_key_t k);
      logic [55:0] r;
      for (int i = 0; i < 56; i++) begin
         r[55-i] = k[64-PC1_TAB[i]];
      end
      return r;
   endfunction

   function automatic des_subkey_t des_pc2(logic [55:0] cd);
      des_subkey_t r;
      for (int i = 0; i < 48; i++) begin
         r[47-i] = cd[56-PC2_TAB[i]];
      end
      return r;
   endfunction

   function automatic des_khalf_t des_rotl(des_khalf_t v, int unsigned n);
      return (v << n) | (v >> (28 - n));
   endfunction

   function automatic des_khalf_t des_rotr(des_khalf_t v, int unsigned n);
      return (v >> n) | (v << (28 - n));
   endfunction

endpackage
